//--- hdl/lsu_pkg.sv
// Shared sizes and enums for the load/store unit; all sizes assume XLEN = 32 and power-of-two counts.
`default_nettype none

package lsu_pkg;

  // ##########################################################
  // Sizes
  // ##########################################################
  localparam int XLEN        = 32;
  localparam int BE_BITS     = XLEN / 8;  // one enable per byte lane.
  localparam int LINE_WORDS  = 4;
  localparam int CACHE_LINES = 16;
  localparam int MEM_WORDS   = 1024;
  localparam int MEM_LATENCY = 3;  // must be at least 2.

  localparam logic [XLEN-1:0] INIT_MULT = 32'h9e37_79b9;

  localparam int OFFSET_BITS   = $clog2(LINE_WORDS);  // word offset inside a line.
  localparam int INDEX_BITS    = $clog2(CACHE_LINES);
  localparam int TAG_BITS      = XLEN - 2 - OFFSET_BITS - INDEX_BITS;
  localparam int WADDR_BITS    = TAG_BITS + INDEX_BITS + OFFSET_BITS;  // word address width.
  localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);

  // ##########################################################
  // Types
  // ##########################################################
  typedef enum logic [3:0] {
    OP_NONE,
    OP_LB,
    OP_LBU,
    OP_LH,
    OP_LHU,
    OP_LW,
    OP_SB,
    OP_SH,
    OP_SW
  } lsu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REFILL,
    ST_WRITE,
    ST_DONE
  } cache_state_e;

endpackage

`default_nettype wire

//--- hdl/load_store.sv
// Combinational load/store unit; accesses must be naturally aligned and op held until done.
`default_nettype none
`timescale 1ns/100ps

module load_store (
  input  logic                       arst_n,
  input  lsu_pkg::lsu_op_e           op,
  input  logic [lsu_pkg::XLEN-1:0]   data_1,
  input  logic [lsu_pkg::XLEN-1:0]   data_2,
  input  logic [lsu_pkg::XLEN-1:0]   immediate,
  output logic [lsu_pkg::XLEN-1:0]   result,
  output logic [lsu_pkg::XLEN-1:0]   result_address,
  output logic                       done,
  output logic [lsu_pkg::XLEN-1:0]   address,
  output logic [lsu_pkg::XLEN-1:0]   wr_data,
  output logic                       read,
  output logic                       write,
  output logic [lsu_pkg::BE_BITS-1:0] write_select,
  input  logic [lsu_pkg::XLEN-1:0]   rd_data,
  input  logic                       hit,
  input  logic                       write_done
);
  import lsu_pkg::*;

  logic [XLEN-1:0]    eff_addr;
  logic [1:0]         lane;
  logic [XLEN-1:0]    ld_shifted;
  logic [XLEN-1:0]    ld_value;
  logic [BE_BITS-1:0] size_mask;

  assign eff_addr   = data_1 + immediate;
  assign lane       = eff_addr[1:0];
  assign ld_shifted = rd_data >> {lane, 3'b000};  // bring the addressed lane down to bit 0.

  // ##########################################################
  // Load extension and store size
  // ##########################################################
  always_comb begin
    case (op)
      OP_LB:   ld_value = {{(XLEN-8){ld_shifted[7]}}, ld_shifted[7:0]};
      OP_LBU:  ld_value = {{(XLEN-8){1'b0}}, ld_shifted[7:0]};
      OP_LH:   ld_value = {{(XLEN-16){ld_shifted[15]}}, ld_shifted[15:0]};
      OP_LHU:  ld_value = {{(XLEN-16){1'b0}}, ld_shifted[15:0]};
      default: ld_value = rd_data;
    endcase
  end

  always_comb begin
    case (op)
      OP_SB:   size_mask = 4'h1;
      OP_SH:   size_mask = 4'h3;
      OP_SW:   size_mask = 4'hf;
      default: size_mask = 4'h0;
    endcase
  end

  // ##########################################################
  // Request and result
  // ##########################################################
  always_comb begin
    result         = '0;
    result_address = '0;
    done           = 1'b0;
    address        = '0;
    wr_data        = '0;
    read           = 1'b0;
    write          = 1'b0;
    write_select   = '0;
    if (arst_n) begin
      case (op)
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
          result  = ld_value;
          done    = hit;  // a hit is the end of a load.
          address = eff_addr;
          read    = 1'b1;
        end
        OP_SB, OP_SH, OP_SW: begin
          if (write_done) begin
            result         = data_2;
            result_address = eff_addr;
            done           = 1'b1;
          end else begin
            address      = eff_addr;
            wr_data      = data_2 << {lane, 3'b000};
            write        = 1'b1;
            write_select = size_mask << lane;
          end
        end
        default: begin
          done = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/data_cache.sv
// Direct-mapped write-through cache without write allocate; one request at a time, address held.
`default_nettype none
`timescale 1ns/100ps

module data_cache (
  input  logic                           clock,
  input  logic                           arst_n,
  input  logic [lsu_pkg::XLEN-1:0]       address,
  input  logic [lsu_pkg::XLEN-1:0]       wr_data,
  input  logic                           read,
  input  logic                           write,
  input  logic [lsu_pkg::BE_BITS-1:0]    write_select,
  output logic [lsu_pkg::XLEN-1:0]       rd_data,
  output logic                           hit,
  output logic                           write_done,
  output logic                           mem_req,
  output logic                           mem_we,
  output logic [lsu_pkg::WADDR_BITS-1:0] mem_addr,
  output logic [lsu_pkg::XLEN-1:0]       mem_wdata,
  output logic [lsu_pkg::BE_BITS-1:0]    mem_be,
  input  logic [lsu_pkg::XLEN-1:0]       mem_rdata,
  input  logic                           mem_ack
);
  import lsu_pkg::*;

  cache_state_e state_q;

  logic [TAG_BITS-1:0]    tag_q   [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_q;
  logic [XLEN-1:0]        data_q  [CACHE_LINES*LINE_WORDS];

  logic [TAG_BITS-1:0]    req_tag;
  logic [INDEX_BITS-1:0]  req_index;
  logic [OFFSET_BITS-1:0] req_offset;
  logic [OFFSET_BITS-1:0] refill_cnt_q;
  logic                   line_match;
  logic                   refill_last;

  assign req_offset = address[OFFSET_BITS+1:2];
  assign req_index  = address[INDEX_BITS+OFFSET_BITS+1:OFFSET_BITS+2];
  assign req_tag    = address[XLEN-1:XLEN-TAG_BITS];

  assign line_match  = valid_q[req_index] && (tag_q[req_index] == req_tag);
  assign hit         = read && line_match;
  assign rd_data     = data_q[{req_index, req_offset}];
  assign write_done  = (state_q == ST_DONE);  // one cycle, the FSM leaves DONE at once.
  assign refill_last = (refill_cnt_q == OFFSET_BITS'(LINE_WORDS - 1));

  // ##########################################################
  // Controller
  // ##########################################################
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q      <= ST_IDLE;
      valid_q      <= '0;
      refill_cnt_q <= '0;
      mem_req      <= 1'b0;
    end else begin
      mem_req <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (read && !line_match) begin
            valid_q[req_index] <= 1'b0;  // the line is rebuilt word by word.
            refill_cnt_q       <= '0;
            mem_req            <= 1'b1;
            state_q            <= ST_REFILL;
          end else if (write) begin
            mem_req <= 1'b1;
            state_q <= ST_WRITE;
          end
        end
        ST_REFILL: begin
          if (mem_ack) begin
            if (refill_last) begin
              valid_q[req_index] <= 1'b1;
              state_q            <= ST_IDLE;
            end else begin
              refill_cnt_q <= refill_cnt_q + 1'b1;
              mem_req      <= 1'b1;
            end
          end
        end
        ST_WRITE: begin
          if (mem_ack) begin
            state_q <= ST_DONE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // memory request payload.
  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE) begin
      mem_we    <= write && !read;
      mem_addr  <= {req_tag, req_index, (read ? {OFFSET_BITS{1'b0}} : req_offset)};
      mem_wdata <= wr_data;
      mem_be    <= write_select;
    end else if (state_q == ST_REFILL && mem_ack) begin
      mem_addr[OFFSET_BITS-1:0] <= refill_cnt_q + 1'b1;  // next word of the line.
    end
  end

  // ##########################################################
  // Tag and data arrays
  // ##########################################################
  always_ff @(posedge clock) begin
    if (state_q == ST_REFILL && mem_ack) begin
      data_q[{req_index, refill_cnt_q}] <= mem_rdata;
      tag_q[req_index]                  <= req_tag;
    end else if (state_q == ST_WRITE && mem_ack && line_match) begin
      for (int b = 0; b < BE_BITS; b++) begin
        if (write_select[b]) begin
          data_q[{req_index, req_offset}][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/backing_memory.sv
// Word memory with fixed latency; one request in flight, address bits above MEM_WORDS are ignored.
`default_nettype none
`timescale 1ns/100ps

module backing_memory (
  input  logic                           clock,
  input  logic                           arst_n,
  input  logic                           mem_req,
  input  logic                           mem_we,
  input  logic [lsu_pkg::WADDR_BITS-1:0] mem_addr,
  input  logic [lsu_pkg::XLEN-1:0]       mem_wdata,
  input  logic [lsu_pkg::BE_BITS-1:0]    mem_be,
  output logic [lsu_pkg::XLEN-1:0]       mem_rdata,
  output logic                           mem_ack
);
  import lsu_pkg::*;

  logic [XLEN-1:0]          mem_q [MEM_WORDS];
  logic [MEM_LATENCY-2:0]   pipe_q;
  logic [MEM_ADDR_BITS-1:0] addr_q;
  logic                     we_q;
  logic [XLEN-1:0]          wdata_q;
  logic [BE_BITS-1:0]       be_q;
  logic                     access;

  assign access = pipe_q[MEM_LATENCY-2];  // the array is touched one cycle before the ack.

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_q[i] = XLEN'(i) * INIT_MULT;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pipe_q  <= '0;
      mem_ack <= 1'b0;
    end else begin
      pipe_q  <= (pipe_q << 1) | (MEM_LATENCY-1)'(mem_req);
      mem_ack <= access;
    end
  end

  always @(posedge clock) begin
    if (mem_req) begin
      addr_q  <= mem_addr[MEM_ADDR_BITS-1:0];
      we_q    <= mem_we;
      wdata_q <= mem_wdata;
      be_q    <= mem_be;
    end
    if (access) begin
      mem_rdata <= mem_q[addr_q];
      if (we_q) begin
        for (int b = 0; b < BE_BITS; b++) begin
          if (be_q[b]) begin
            mem_q[addr_q][8*b +: 8] <= wdata_q[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
// Load/store unit, cache and memory; the requester holds op and operands until done is seen high.
`default_nettype none
`timescale 1ns/100ps

module lsu_top (
  input  logic                     clock,
  input  logic                     arst_n,
  input  lsu_pkg::lsu_op_e         op,
  input  logic [lsu_pkg::XLEN-1:0] data_1,
  input  logic [lsu_pkg::XLEN-1:0] data_2,
  input  logic [lsu_pkg::XLEN-1:0] immediate,
  output logic [lsu_pkg::XLEN-1:0] result,
  output logic [lsu_pkg::XLEN-1:0] result_address,
  output logic                     done
);
  import lsu_pkg::*;

  // ##########################################################
  // Unit to cache
  // ##########################################################
  logic [XLEN-1:0]    address;
  logic [XLEN-1:0]    wr_data;
  logic               read;
  logic               write;
  logic [BE_BITS-1:0] write_select;
  logic [XLEN-1:0]    rd_data;
  logic               hit;
  logic               write_done;

  // ##########################################################
  // Cache to memory
  // ##########################################################
  logic                  mem_req;
  logic                  mem_we;
  logic [WADDR_BITS-1:0] mem_addr;
  logic [XLEN-1:0]       mem_wdata;
  logic [BE_BITS-1:0]    mem_be;
  logic [XLEN-1:0]       mem_rdata;
  logic                  mem_ack;

  load_store u_load_store (
    .arst_n(arst_n), .op(op), .data_1(data_1), .data_2(data_2), .immediate(immediate),
    .result(result), .result_address(result_address), .done(done),
    .address(address), .wr_data(wr_data), .read(read), .write(write),
    .write_select(write_select), .rd_data(rd_data), .hit(hit), .write_done(write_done)
  );

  data_cache u_data_cache (
    .clock(clock), .arst_n(arst_n), .address(address), .wr_data(wr_data),
    .read(read), .write(write), .write_select(write_select),
    .rd_data(rd_data), .hit(hit), .write_done(write_done),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_be(mem_be), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
  );

  backing_memory u_backing_memory (
    .clock(clock), .arst_n(arst_n), .mem_req(mem_req), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_be(mem_be),
    .mem_rdata(mem_rdata), .mem_ack(mem_ack)
  );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// Free-running testbench clock with a 100 ns period that starts low at time zero.
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clock
);
  localparam int HALF_PERIOD = 50;

  initial begin
    clock = 1'b0;
    forever begin
      #HALF_PERIOD clock = ~clock;
    end
  end

endmodule

`default_nettype wire

//--- tb/lsu_assertions.sv
// Concurrent checks on the unit, cache and memory timing; all are off while arst_n is low.
`default_nettype none
`timescale 1ns/100ps

module lsu_assertions (
  input logic                  clock,
  input logic                  arst_n,
  input lsu_pkg::lsu_op_e      op,
  input logic                  done,
  input logic                  read,
  input logic                  write,
  input logic                  write_done,
  input lsu_pkg::cache_state_e state,
  input logic                  mem_req,
  input logic                  mem_ack
);
  import lsu_pkg::*;

  // ##########################################################
  // Unit and cache
  // ##########################################################
  read_write_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
    !(read && write)) else $error("read and write are high together");

  write_done_in_done_state: assert property (@(posedge clock) disable iff (!arst_n)
    write_done |-> state == ST_DONE && $past(state == ST_WRITE && mem_ack))
    else $error("write_done is high outside ST_DONE or without an acknowledged write");

  done_low_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
    op == OP_NONE |-> !done) else $error("done is high while op is OP_NONE");

  // ##########################################################
  // Memory latency
  // ##########################################################
  ack_after_req: assert property (@(posedge clock) disable iff (!arst_n)
    $past(mem_req, MEM_LATENCY) |-> mem_ack) else $error("mem_ack missing after mem_req");

  no_stray_ack: assert property (@(posedge clock) disable iff (!arst_n)
    mem_ack |-> $past(mem_req, MEM_LATENCY)) else $error("mem_ack without an earlier mem_req");

endmodule

`default_nettype wire

//--- tb/lsu_tb.sv
// Random self-checking test of lsu_top; addresses stay inside the memory so no word aliases.
`default_nettype none
`timescale 1ns/100ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 4;
  localparam int MEM_BYTES    = MEM_WORDS * 4;
  localparam int MIX_SPAN     = 1024;  // four tags compete for each cache index.
  localparam int TAG_STEP     = 1 << (INDEX_BITS + OFFSET_BITS + 2);
  localparam int N_INIT       = 40;
  localparam int N_REPEAT     = 8;
  localparam int N_STORES     = 30;
  localparam int N_PAIRS      = 16;
  localparam int N_MIX        = 300;
  localparam int N_IDLE_OPS   = 12;
  localparam int MAX_GAP      = 4;
  localparam int OP_BOUND     = LINE_WORDS * (MEM_LATENCY + 1) + MEM_LATENCY + 2 + MAX_GAP + 8;
  localparam int TOTAL_OPS    = N_INIT + N_REPEAT * 2 * LINE_WORDS + N_STORES + N_PAIRS * 6
                                + N_MIX + N_IDLE_OPS;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 8 + TOTAL_OPS * OP_BOUND;

  logic            clock;
  logic            arst_n;
  lsu_op_e         op;
  logic [XLEN-1:0] data_1;
  logic [XLEN-1:0] data_2;
  logic [XLEN-1:0] immediate;
  logic [XLEN-1:0] result;
  logic [XLEN-1:0] result_address;
  logic            done;

  logic [XLEN-1:0] model_mem [MEM_WORDS];
  integer          seed;
  string           test_name;
  int              test_errors;
  int              checks;
  int              errors;
  int              tests_run;

  tb_clock_gen u_clock_gen (.clock(clock));

  lsu_top UUT (
    .clock(clock), .arst_n(arst_n), .op(op), .data_1(data_1), .data_2(data_2),
    .immediate(immediate), .result(result), .result_address(result_address), .done(done)
  );

  bind lsu_top lsu_assertions u_lsu_assertions (
    .clock(clock), .arst_n(arst_n), .op(op), .done(done), .read(read), .write(write),
    .write_done(write_done), .state(u_data_cache.state_q), .mem_req(mem_req), .mem_ack(mem_ack)
  );

  // ##########################################################
  // Reference model
  // ##########################################################
  function automatic logic [XLEN-1:0] expected_load(lsu_op_e kind, logic [XLEN-1:0] addr);
    logic [XLEN-1:0] word;
    logic [7:0]      byte_val;
    logic [15:0]     half_val;
    word     = model_mem[addr[MEM_ADDR_BITS+1:2]];
    byte_val = word[8*addr[1:0] +: 8];
    half_val = addr[1] ? word[31:16] : word[15:0];
    case (kind)
      OP_LB:   return {{24{byte_val[7]}}, byte_val};
      OP_LBU:  return {24'h0, byte_val};
      OP_LH:   return {{16{half_val[15]}}, half_val};
      OP_LHU:  return {16'h0, half_val};
      default: return word;
    endcase
  endfunction

  function automatic void apply_store(lsu_op_e kind, logic [XLEN-1:0] addr,
                                      logic [XLEN-1:0] value);
    logic [XLEN-1:0] word;
    word = model_mem[addr[MEM_ADDR_BITS+1:2]];
    case (kind)
      OP_SB:   word[8*addr[1:0] +: 8] = value[7:0];
      OP_SH:   word[16*addr[1] +: 16] = value[15:0];
      default: word = value;
    endcase
    model_mem[addr[MEM_ADDR_BITS+1:2]] = word;
  endfunction

  function automatic lsu_op_e random_kind(int first, int choices);
    logic [XLEN-1:0] pick;
    pick = $random(seed);
    case (first + int'(pick % choices))
      0:       return OP_LB;
      1:       return OP_LBU;
      2:       return OP_LH;
      3:       return OP_LHU;
      4:       return OP_LW;
      5:       return OP_SB;
      6:       return OP_SH;
      default: return OP_SW;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] random_addr(lsu_op_e kind, int span);
    logic [XLEN-1:0] addr;
    addr = $random(seed);
    addr = addr % span;
    case (kind)
      OP_LH, OP_LHU, OP_SH: addr[0] = 1'b0;
      OP_LW, OP_SW:         addr[1:0] = 2'b00;
      default: ;
    endcase
    return addr;
  endfunction

  // ##########################################################
  // Driving and checking
  // ##########################################################
  task automatic report_mismatch(string what, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
    errors++;
    test_errors++;
    $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
  endtask

  task automatic idle_cycles(int n);
    op = OP_NONE;
    repeat (n) begin
      @(negedge clock);
      checks++;
      if (done !== 1'b0) begin
        errors++;
        test_errors++;
        $display("%s: done is high while no operation is presented", test_name);
      end
      @(posedge clock);
      #DRIVE_DELAY;
    end
  endtask

  task automatic run_op(lsu_op_e kind, logic [XLEN-1:0] addr, logic [XLEN-1:0] value);
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] exp_result;
    logic [XLEN-1:0] exp_address;
    logic            store;
    imm         = $random(seed);
    imm         = {{20{imm[11]}}, imm[11:0]};  // same range as an I-type immediate.
    store       = kind inside {OP_SB, OP_SH, OP_SW};
    exp_result  = store ? value : expected_load(kind, addr);
    exp_address = store ? addr : '0;
    op          = kind;
    data_1      = addr - imm;
    data_2      = value;
    immediate   = imm;
    do begin
      @(negedge clock);
    end while (!done);
    checks += 2;
    if (result !== exp_result) begin
      report_mismatch("result", exp_result, result);
    end
    if (result_address !== exp_address) begin
      report_mismatch("result_address", exp_address, result_address);
    end
    if (store) begin
      apply_store(kind, addr, value);
    end
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s finished with %0d error(s)", test_name, test_errors);
  endtask

  // ##########################################################
  // Test sequence
  // ##########################################################
  initial begin : stimulus
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] word_addr;
    logic [XLEN-1:0] fill;
    logic [XLEN-1:0] gap;
    lsu_op_e         kind;
    seed      = 32'he6bb_1084;
    arst_n    = 1'b0;
    op        = OP_NONE;
    data_1    = '0;
    data_2    = '0;
    immediate = '0;
    checks    = 0;
    errors    = 0;
    tests_run = 0;
    fill      = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = fill;  // word i holds i times INIT_MULT.
      fill         = fill + INIT_MULT;
    end

    begin_test("reset_idle");
    idle_cycles(RESET_CYCLES);
    arst_n = 1'b1;
    idle_cycles(8);
    end_test();

    begin_test("initial_loads");
    repeat (N_INIT) begin
      kind = random_kind(0, 5);
      run_op(kind, random_addr(kind, MEM_BYTES), $random(seed));
    end
    end_test();

    begin_test("repeated_loads");
    repeat (N_REPEAT) begin
      addr = random_addr(OP_LW, MEM_BYTES);
      addr[OFFSET_BITS+1:0] = '0;
      repeat (2) begin
        for (int w = 0; w < LINE_WORDS; w++) begin
          run_op(OP_LW, addr + 4 * w, '0);
        end
      end
    end
    end_test();

    begin_test("stores");
    repeat (N_STORES) begin
      kind = random_kind(5, 3);
      run_op(kind, random_addr(kind, MEM_BYTES), $random(seed));
    end
    end_test();

    begin_test("load_after_store");
    repeat (N_PAIRS) begin
      kind      = random_kind(5, 3);
      addr      = random_addr(kind, MEM_BYTES);
      word_addr = {addr[XLEN-1:2], 2'b00};
      run_op(OP_LW, word_addr, '0);
      run_op(kind, addr, $random(seed));
      run_op(OP_LW, word_addr, '0);
      kind      = random_kind(5, 3);
      addr      = random_addr(kind, MEM_BYTES);
      word_addr = {addr[XLEN-1:2], 2'b00};
      run_op(OP_LW, word_addr ^ TAG_STEP, '0);  // same index with another tag evicts the line.
      run_op(kind, addr, $random(seed));
      run_op(OP_LW, word_addr, '0);
    end
    end_test();

    begin_test("random_mix");
    repeat (N_MIX) begin
      kind = random_kind(0, 8);
      run_op(kind, random_addr(kind, MIX_SPAN), $random(seed));
      gap = $random(seed);
      if (gap[1:0] == 2'b00) begin
        idle_cycles(1 + int'(gap[3:2]));
      end
    end
    end_test();

    begin_test("idle_gaps");
    repeat (N_IDLE_OPS) begin
      kind = random_kind(0, 8);
      run_op(kind, random_addr(kind, MIX_SPAN), $random(seed));
      idle_cycles(MAX_GAP);
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout waiting for done in test %s", test_name);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- lsu.f
hdl/lsu_pkg.sv
hdl/load_store.sv
hdl/data_cache.sv
hdl/backing_memory.sv
hdl/lsu_top.sv
tb/tb_clock_gen.sv
tb/lsu_assertions.sv
tb/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module lsu_tb -f lsu.f -o lsu_sim &&
{ ./obj_dir/lsu_sim > sim.log 2>&1; cat sim.log; } &&
! grep -q "SIMULATION FAILED" sim.log &&
grep -q "SIMULATION PASSED" sim.log &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }
